// ==== tour_defines.svh ====
`ifndef TOUR_DEFINES_SVH
`define TOUR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// board and tour dimensions
//////////////////////////////////////////////////////////////////////

// side of the square board
`define BOARD_DIM 5

// moves in a full tour, one less than the square count
`define TOUR_MOVES 24

// two straight segments per knight move
`define TOUR_SEGS 48

`endif

// ==== tour_pkg.sv ====
`include "tour_defines.svh"

package tour_pkg;

  //////////////////////////////////////////////////////////////////////
  // board types
  //////////////////////////////////////////////////////////////////////

  // square coordinate along one axis, 0 to 4
  typedef logic [2:0] coord_t;

  // one-hot move code, bit i selects offset pair i
  typedef logic [7:0] move_t;

  // move number or readout index
  typedef logic [4:0] move_idx_t;

  // signed step along one axis, -2 to 2
  typedef logic signed [2:0] offset_t;

  //////////////////////////////////////////////////////////////////////
  // move offsets
  //////////////////////////////////////////////////////////////////////

  // x step of a one-hot move, zero for anything not one-hot
  function automatic offset_t off_x(input move_t m);
    offset_t o;
    case (m)
      8'b0000_0001: o = 3'sd1;
      8'b0000_0010: o = -3'sd1;
      8'b0000_0100: o = -3'sd2;
      8'b0000_1000: o = -3'sd2;
      8'b0001_0000: o = -3'sd1;
      8'b0010_0000: o = 3'sd1;
      8'b0100_0000: o = 3'sd2;
      8'b1000_0000: o = 3'sd2;
      default:      o = 3'sd0;
    endcase
    return o;
  endfunction

  // y step of a one-hot move
  function automatic offset_t off_y(input move_t m);
    offset_t o;
    case (m)
      8'b0000_0001: o = 3'sd2;
      8'b0000_0010: o = 3'sd2;
      8'b0000_0100: o = 3'sd1;
      8'b0000_1000: o = -3'sd1;
      8'b0001_0000: o = -3'sd2;
      8'b0010_0000: o = -3'sd2;
      8'b0100_0000: o = -3'sd1;
      8'b1000_0000: o = 3'sd1;
      default:      o = 3'sd0;
    endcase
    return o;
  endfunction

  // coordinate plus a signed step, wraps when off the board
  function automatic coord_t neighbor(input coord_t c, input offset_t o);
    logic signed [3:0] sum;
    sum = $signed({1'b0, c}) + o;
    return coord_t'(sum[2:0]);
  endfunction

  // every move that stays on the board from square (x, y)
  function automatic move_t legal_moves(input coord_t x, input coord_t y);
    move_t             m;
    move_t             ok;
    logic signed [3:0] nx;
    logic signed [3:0] ny;
    ok = '0;
    for (int i = 0; i < 8; i++) begin
      m  = move_t'(1) << i;
      nx = $signed({1'b0, x}) + off_x(m);
      ny = $signed({1'b0, y}) + off_y(m);
      // landing square must sit inside both axes
      ok[i] = (nx >= 0) && (nx < `BOARD_DIM) && (ny >= 0) && (ny < `BOARD_DIM);
    end
    return ok;
  endfunction

endpackage

// ==== cmd_pkg.sv ====
package cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // motion command types
  //////////////////////////////////////////////////////////////////////

  // direction of a straight segment
  // north is +y, east is +x
  typedef enum logic [1:0] {
    NORTH,
    EAST,
    SOUTH,
    WEST
  } heading_t;

  // squares to travel, 1 or 2 for a knight segment
  typedef logic [1:0] seg_len_t;

  // one segment command as sent to the motion system
  typedef struct packed {
    heading_t heading;
    seg_len_t len;
  } seg_cmd_t;

endpackage

// ==== tour_logic.sv ====
`timescale 1ns/100ps
`include "tour_defines.svh"

module tour_logic (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  tour_pkg::coord_t    x_start,
  input  tour_pkg::coord_t    y_start,
  input  tour_pkg::move_idx_t indx,
  output logic                done,
  output tour_pkg::move_t     move
);

  localparam int NUM_SQ = `BOARD_DIM * `BOARD_DIM;
  localparam int SQ_W   = $clog2(NUM_SQ);

  // deepest level, the move that completes the tour
  localparam tour_pkg::move_idx_t LAST_LVL = tour_pkg::move_idx_t'(`TOUR_MOVES - 1);
  // index the sequencer holds while no readout is under way
  localparam tour_pkg::move_idx_t PARKED   = tour_pkg::move_idx_t'(`TOUR_MOVES);

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    POSSIBLE,
    MAKE_MOVE,
    BACKUP
  } state_t;

  state_t state;
  state_t nxt_state;

  // visited flag per square, y major
  logic [NUM_SQ-1:0] visited;

  // per level storage
  tour_pkg::move_t poss_moves [`TOUR_MOVES];
  tour_pkg::move_t last_move [`TOUR_MOVES];

  tour_pkg::move_t     move_try;
  tour_pkg::move_idx_t move_num;
  tour_pkg::coord_t    xx;
  tour_pkg::coord_t    yy;

  // landing square of the current candidate
  tour_pkg::coord_t nxt_x;
  tour_pkg::coord_t nxt_y;

  // square one level back when unwinding
  tour_pkg::move_t  prev_move;
  tour_pkg::coord_t back_x;
  tour_pkg::coord_t back_y;

  logic readout_busy;
  logic cand_ok;

  // fsm strobes
  logic start;
  logic init;
  logic calc;
  logic take;
  logic step;
  logic backup;

  // flat square number
  function automatic logic [SQ_W-1:0] sq_idx(input tour_pkg::coord_t x,
                                             input tour_pkg::coord_t y);
    return SQ_W'(y * `BOARD_DIM + x);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // datapath decode
  //////////////////////////////////////////////////////////////////////

  // solver must not overwrite a tour that is still being read out
  assign readout_busy = (indx != PARKED);

  assign nxt_x = tour_pkg::neighbor(xx, tour_pkg::off_x(move_try));
  assign nxt_y = tour_pkg::neighbor(yy, tour_pkg::off_y(move_try));

  // candidate stays on the board and lands on a fresh square
  assign cand_ok = |(poss_moves[move_num] & move_try) && !visited[sq_idx(nxt_x, nxt_y)];

  // undo the move that brought us to this level
  assign prev_move = last_move[move_num - 1'b1];
  assign back_x    = tour_pkg::neighbor(xx, -tour_pkg::off_x(prev_move));
  assign back_y    = tour_pkg::neighbor(yy, -tour_pkg::off_y(prev_move));

  //////////////////////////////////////////////////////////////////////
  // search fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = state;
    start     = 1'b0;
    init      = 1'b0;
    calc      = 1'b0;
    take      = 1'b0;
    step      = 1'b0;
    backup    = 1'b0;
    done      = 1'b0;
    case (state)
      IDLE: begin
        if (go && !readout_busy) begin
          start     = 1'b1;
          nxt_state = INIT;
        end
      end
      INIT: begin
        init      = 1'b1;
        nxt_state = POSSIBLE;
      end
      POSSIBLE: begin
        calc      = 1'b1;
        nxt_state = MAKE_MOVE;
      end
      MAKE_MOVE: begin
        if (cand_ok) begin
          take = 1'b1;
          if (move_num == LAST_LVL) begin
            done      = 1'b1;
            nxt_state = IDLE;
          end else begin
            nxt_state = POSSIBLE;
          end
        end else if (move_try != 8'h80) begin
          // hold here and try the next candidate
          step = 1'b1;
        end else begin
          nxt_state = BACKUP;
        end
      end
      BACKUP: begin
        backup = 1'b1;
        // level above also exhausted, keep unwinding
        if (prev_move != 8'h80) begin
          nxt_state = MAKE_MOVE;
        end
      end
      default: begin
        nxt_state = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////

  // knight position
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xx <= '0;
      yy <= '0;
    end else if (start) begin
      xx <= x_start;
      yy <= y_start;
    end else if (take) begin
      xx <= nxt_x;
      yy <= nxt_y;
    end else if (backup) begin
      xx <= back_x;
      yy <= back_y;
    end
  end

  // level counter, stays on the last level once the tour is placed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      move_num <= '0;
    end else if (init) begin
      move_num <= '0;
    end else if (take && (move_num != LAST_LVL)) begin
      move_num <= move_num + 1'b1;
    end else if (backup) begin
      move_num <= move_num - 1'b1;
    end
  end

  // candidate walker, resumes above the undone move after a backup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      move_try <= '0;
    end else if (calc) begin
      move_try <= 8'h01;
    end else if (step) begin
      move_try <= move_try << 1;
    end else if (backup) begin
      move_try <= prev_move << 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // board and level memories
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (init) begin
      visited                 <= '0;
      visited[sq_idx(xx, yy)] <= 1'b1;
    end else if (take) begin
      visited[sq_idx(nxt_x, nxt_y)] <= 1'b1;
    end else if (backup) begin
      visited[sq_idx(xx, yy)] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (calc) begin
      poss_moves[move_num] <= tour_pkg::legal_moves(xx, yy);
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      last_move[move_num] <= move_try;
    end
  end

  // readout for the sequencer
  assign move = last_move[indx];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // no tour exists from the minority colour
  a_even_start: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (x_start[0] == y_start[0]));

  a_try_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(move_try));

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    (state == BACKUP) |-> (move_num != '0));

  // a finished search has covered every square
  a_full_board: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> (&visited));

endmodule

// ==== tour_cmd.sv ====
`timescale 1ns/100ps
`include "tour_defines.svh"

module tour_cmd (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                done,
  input  tour_pkg::move_t     move,
  input  logic                seg_done,
  output tour_pkg::move_idx_t indx,
  output logic                cmd_valid,
  output cmd_pkg::seg_cmd_t   cmd,
  output logic                tour_complete
);

  localparam tour_pkg::move_idx_t LAST_IDX = tour_pkg::move_idx_t'(`TOUR_MOVES - 1);
  // out of range index, tells the solver the tour memory is free
  localparam tour_pkg::move_idx_t PARKED   = tour_pkg::move_idx_t'(`TOUR_MOVES);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    Y_SEG,
    WAIT_Y,
    X_SEG,
    WAIT_X,
    FINISH
  } state_t;

  state_t state;
  state_t nxt_state;

  tour_pkg::offset_t dx;
  tour_pkg::offset_t dy;

  // index strobes
  logic restart;
  logic advance;
  logic park;

  // segment length is the step magnitude
  function automatic cmd_pkg::seg_len_t seg_mag(input tour_pkg::offset_t o);
    tour_pkg::offset_t a;
    a = (o < 0) ? -o : o;
    return cmd_pkg::seg_len_t'(a[1:0]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // move decode
  //////////////////////////////////////////////////////////////////////

  assign dx = tour_pkg::off_x(move);
  assign dy = tour_pkg::off_y(move);

  // y leg first, x leg second
  always_comb begin
    if (state == X_SEG) begin
      cmd.heading = (dx > 0) ? cmd_pkg::EAST : cmd_pkg::WEST;
      cmd.len     = seg_mag(dx);
    end else begin
      cmd.heading = (dy > 0) ? cmd_pkg::NORTH : cmd_pkg::SOUTH;
      cmd.len     = seg_mag(dy);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequencer fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state     = state;
    restart       = 1'b0;
    advance       = 1'b0;
    park          = 1'b0;
    cmd_valid     = 1'b0;
    tour_complete = 1'b0;
    case (state)
      IDLE: begin
        if (done) begin
          restart   = 1'b1;
          nxt_state = FETCH;
        end
      end
      // first move read from the solver memory
      FETCH: begin
        nxt_state = Y_SEG;
      end
      Y_SEG: begin
        cmd_valid = 1'b1;
        nxt_state = WAIT_Y;
      end
      WAIT_Y: begin
        if (seg_done) begin
          nxt_state = X_SEG;
        end
      end
      X_SEG: begin
        cmd_valid = 1'b1;
        nxt_state = WAIT_X;
      end
      WAIT_X: begin
        if (seg_done) begin
          if (indx == LAST_IDX) begin
            park      = 1'b1;
            nxt_state = FINISH;
          end else begin
            // next move is read while its y leg is issued
            advance   = 1'b1;
            nxt_state = Y_SEG;
          end
        end
      end
      FINISH: begin
        tour_complete = 1'b1;
        nxt_state     = IDLE;
      end
      default: begin
        nxt_state = IDLE;
      end
    endcase
  end

  // readout index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      indx <= PARKED;
    end else if (restart) begin
      indx <= '0;
    end else if (advance) begin
      indx <= indx + 1'b1;
    end else if (park) begin
      indx <= PARKED;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // motion system only answers an issued segment
  a_done_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    seg_done |-> ((state == WAIT_Y) || (state == WAIT_X)));

  a_move_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    ((state == Y_SEG) || (state == X_SEG)) |-> $onehot(move));

endmodule

// ==== knights_tour_top.sv ====
`timescale 1ns/100ps

module knights_tour_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              go,
  input  tour_pkg::coord_t  x_start,
  input  tour_pkg::coord_t  y_start,
  input  logic              seg_done,
  output logic              cmd_valid,
  output cmd_pkg::seg_cmd_t cmd,
  output logic              tour_complete
);

  // solver to sequencer
  logic                done;
  tour_pkg::move_idx_t indx;
  tour_pkg::move_t     move;

  //////////////////////////////////////////////////////////////////////
  // tour search
  //////////////////////////////////////////////////////////////////////

  tour_logic u_logic (
    .clk     (clk),
    .rst_n   (rst_n),
    .go      (go),
    .x_start (x_start),
    .y_start (y_start),
    .indx    (indx),
    .done    (done),
    .move    (move)
  );

  //////////////////////////////////////////////////////////////////////
  // segment sequencer
  //////////////////////////////////////////////////////////////////////

  tour_cmd u_cmd (
    .clk           (clk),
    .rst_n         (rst_n),
    .done          (done),
    .move          (move),
    .seg_done      (seg_done),
    .indx          (indx),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .tour_complete (tour_complete)
  );

endmodule

// ==== tb_knights_tour.sv ====
`timescale 1ns/100ps
`include "tour_defines.svh"

module tb_knights_tour;

  // four searches plus the segment phase of each tour
  localparam int MAX_CYCLES = 4 * (2000000 + `TOUR_SEGS * 22);
  localparam int NUM_SQ     = `BOARD_DIM * `BOARD_DIM;

  logic                clk;
  logic                rst_n;
  logic                go;
  tour_pkg::coord_t    x_start;
  tour_pkg::coord_t    y_start;
  logic                seg_done;
  logic                cmd_valid;
  cmd_pkg::seg_cmd_t   cmd;
  logic                tour_complete;

  // reference model state
  bit                ref_board [`BOARD_DIM][`BOARD_DIM];
  int                ref_path [`TOUR_MOVES];
  cmd_pkg::seg_cmd_t exp_seg [`TOUR_SEGS];

  // monitor state
  bit    mon_board [`BOARD_DIM][`BOARD_DIM];
  int    pos_x;
  int    pos_y;
  int    visit_cnt;
  int    seg_cnt;
  int    done_cnt;
  int    tours_done;
  int    cycles;
  bit    tour_active;
  bit    go_seen;
  bit    outstanding;
  bit    prev_seg_done;
  bit    complete_due;
  bit    exp_complete;
  bit    exp_valid;
  string test_name;

  int err_value;
  int err_legal;
  int err_pacing;
  int err_timeout;

  knights_tour_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .go            (go),
    .x_start       (x_start),
    .y_start       (y_start),
    .seg_done      (seg_done),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .tour_complete (tour_complete)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference search
  //////////////////////////////////////////////////////////////////////

  // knight offsets in candidate order starting at bit 0
  function automatic int jump_dx(input int i);
    case (i)
      0: return 1;
      1: return -1;
      2: return -2;
      3: return -2;
      4: return -1;
      5: return 1;
      default: return 2;
    endcase
  endfunction

  function automatic int jump_dy(input int i);
    case (i)
      0: return 2;
      1: return 2;
      2: return 1;
      3: return -1;
      4: return -2;
      5: return -2;
      6: return -1;
      default: return 1;
    endcase
  endfunction

  // depth first search where the first hit in rising candidate order wins
  function automatic bit search_from(input int x, input int y, input int lvl);
    int nx;
    int ny;
    int i;
    bit found;
    if (lvl == `TOUR_MOVES) return 1'b1;
    found = 1'b0;
    for (i = 0; (i < 8) && !found; i++) begin
      nx = x + jump_dx(i);
      ny = y + jump_dy(i);
      if ((nx >= 0) && (nx < `BOARD_DIM) && (ny >= 0) && (ny < `BOARD_DIM)) begin
        if (!ref_board[nx][ny]) begin
          ref_board[nx][ny] = 1'b1;
          ref_path[lvl]     = i;
          if (search_from(nx, ny, lvl + 1)) found = 1'b1;
          else ref_board[nx][ny] = 1'b0;
        end
      end
    end
    return found;
  endfunction

  // y leg then x leg for every move of the model tour
  task automatic build_expected(input int sx, input int sy);
    int dx;
    int dy;
    foreach (ref_board[i, j]) ref_board[i][j] = 1'b0;
    ref_board[sx][sy] = 1'b1;
    void'(search_from(sx, sy, 0));
    for (int m = 0; m < `TOUR_MOVES; m++) begin
      dx = jump_dx(ref_path[m]);
      dy = jump_dy(ref_path[m]);
      exp_seg[2*m].heading   = (dy > 0) ? cmd_pkg::NORTH : cmd_pkg::SOUTH;
      exp_seg[2*m].len       = cmd_pkg::seg_len_t'((dy > 0) ? dy : -dy);
      exp_seg[2*m+1].heading = (dx > 0) ? cmd_pkg::EAST : cmd_pkg::WEST;
      exp_seg[2*m+1].len     = cmd_pkg::seg_len_t'((dx > 0) ? dx : -dx);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // motion responder
  //////////////////////////////////////////////////////////////////////

  // seg_done 1 to 20 cycles after each command
  task automatic respond_to_commands();
    int wait_cnt;
    wait_cnt = 0;
    forever begin
      @(negedge clk);
      seg_done <= 1'b0;
      if (!rst_n) begin
        wait_cnt = 0;
      end else begin
        if (wait_cnt > 0) begin
          if (wait_cnt == 1) seg_done <= 1'b1;
          wait_cnt--;
        end
        if (cmd_valid) wait_cnt = $urandom_range(1, 20);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////////////////////////

  // compare the value and then walk the knight by the commanded segments
  task automatic check_segment();
    cmd_pkg::seg_cmd_t want;
    int                step;
    bit                on_board;
    want = exp_seg[seg_cnt];
    assert (cmd == want) else begin
      err_value++;
      $display("[ERROR] %s segment %0d: expected %s %0d, actual %s %0d", test_name, seg_cnt,
               want.heading.name(), want.len, cmd.heading.name(), cmd.len);
    end
    step = int'(cmd.len);
    case (cmd.heading)
      cmd_pkg::NORTH: pos_y = pos_y + step;
      cmd_pkg::SOUTH: pos_y = pos_y - step;
      cmd_pkg::EAST:  pos_x = pos_x + step;
      default:        pos_x = pos_x - step;
    endcase
    // a knight move ends on the x leg
    if (seg_cnt % 2 == 1) begin
      on_board = (pos_x >= 0) && (pos_x < `BOARD_DIM) && (pos_y >= 0) && (pos_y < `BOARD_DIM);
      assert (on_board) else begin
        err_legal++;
        $display("%s: knight left the board after segment %0d", test_name, seg_cnt);
      end
      if (on_board) begin
        assert (!mon_board[pos_x][pos_y]) else begin
          err_legal++;
          $display("%s: square (%0d,%0d) visited twice", test_name, pos_x, pos_y);
        end
        mon_board[pos_x][pos_y] = 1'b1;
        visit_cnt++;
      end
    end
    seg_cnt++;
    outstanding = 1'b1;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      assert (!cmd_valid && !tour_complete) else begin
        err_pacing++;
        $display("cmd_valid or tour_complete went high during reset");
      end
      prev_seg_done = 1'b0;
      complete_due  = 1'b0;
      outstanding   = 1'b0;
      tour_active   = 1'b0;
    end else begin
      exp_complete = complete_due;
      complete_due = 1'b0;
      if (!go_seen) begin
        assert (!cmd_valid && !tour_complete) else begin
          err_pacing++;
          $display("output activity before the first go");
        end
      end
      // a go while a tour is in progress must be ignored
      if (go && !tour_active) begin
        go_seen     = 1'b1;
        tour_active = 1'b1;
        foreach (mon_board[i, j]) mon_board[i][j] = 1'b0;
        pos_x                   = int'(x_start);
        pos_y                   = int'(y_start);
        mon_board[pos_x][pos_y] = 1'b1;
        visit_cnt               = 1;
        seg_cnt                 = 0;
        done_cnt                = 0;
      end
      if (tour_active && (seg_cnt > 0)) begin
        exp_valid = prev_seg_done && (seg_cnt < `TOUR_SEGS);
        assert (cmd_valid == exp_valid) else begin
          err_pacing++;
          $display("[ERROR] %s cmd_valid after segment %0d: expected %0b, actual %0b",
                   test_name, seg_cnt, exp_valid, cmd_valid);
        end
      end else if (!tour_active) begin
        assert (!cmd_valid) else begin
          err_pacing++;
          $display("cmd_valid outside a tour");
        end
      end
      if (cmd_valid && tour_active && (seg_cnt < `TOUR_SEGS) && !outstanding) check_segment();
      if (seg_done) begin
        outstanding = 1'b0;
        done_cnt++;
        if (done_cnt == `TOUR_SEGS) complete_due = 1'b1;
      end
      assert (tour_complete == exp_complete) else begin
        err_pacing++;
        $display("[ERROR] %s tour_complete: expected %0b, actual %0b",
                 test_name, exp_complete, tour_complete);
      end
      if (tour_complete && exp_complete) begin
        assert ((visit_cnt == NUM_SQ) && (seg_cnt == `TOUR_SEGS)) else begin
          err_legal++;
          $display("%s: tour ended with %0d squares and %0d segments",
                   test_name, visit_cnt, seg_cnt);
        end
        tour_active = 1'b0;
        tours_done++;
      end
      prev_seg_done = seg_done;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  task automatic finish_run();
    int total;
    total = err_value + err_legal + err_pacing + err_timeout;
    $display("errors: %0d value, %0d legality, %0d pacing, %0d timeout, %0d total",
             err_value, err_legal, err_pacing, err_timeout, total);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      err_timeout++;
      $display("timeout: the tours did not finish within %0d cycles", MAX_CYCLES);
      finish_run();
    end
  end

  // one tour from (sx, sy) with an optional stray go mid stream
  task automatic run_tour(input string name, input int sx, input int sy,
                          input bit poke, input int px, input int py);
    int start_count;
    test_name = name;
    build_expected(sx, sy);
    start_count = tours_done;
    x_start = tour_pkg::coord_t'(sx);
    y_start = tour_pkg::coord_t'(sy);
    go      = 1'b1;
    @(negedge clk);
    go = 1'b0;
    if (poke) begin
      while (seg_cnt < 10) @(negedge clk);
      x_start = tour_pkg::coord_t'(px);
      y_start = tour_pkg::coord_t'(py);
      go      = 1'b1;
      @(negedge clk);
      go = 1'b0;
    end
    while (tours_done == start_count) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    int seed_ret;
    int cx;
    int cy;
    int rx;
    int ry;
    int px;
    int py;
    seed_ret = $urandom(32'hfb473e52);
    clk      = 1'b0;
    rst_n    = 1'b0;
    go       = 1'b0;
    x_start  = '0;
    y_start  = '0;
    seg_done = 1'b0;
    // responder latencies follow from the seed of this process
    fork
      respond_to_commands();
    join_none
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // outputs must stay quiet until the first go
    repeat (5) @(negedge clk);
    cx = ($urandom_range(0, 1) == 1) ? `BOARD_DIM - 1 : 0;
    cy = ($urandom_range(0, 1) == 1) ? `BOARD_DIM - 1 : 0;
    run_tour("tour0_corner", cx, cy, 1'b0, 0, 0);
    run_tour("tour1_centre", 2, 2, 1'b1, cx, cy);
    px = 2;
    py = 2;
    for (int t = 2; t < 4; t++) begin
      rx = px;
      ry = py;
      while ((((rx + ry) % 2) != 0) || ((rx == px) && (ry == py))) begin
        rx = $urandom_range(0, `BOARD_DIM - 1);
        ry = $urandom_range(0, `BOARD_DIM - 1);
      end
      run_tour($sformatf("tour%0d_random", t), rx, ry, 1'b0, 0, 0);
      px = rx;
      py = ry;
    end
    finish_run();
  end

endmodule

// ==== project.f ====
+incdir+.
tour_pkg.sv
cmd_pkg.sv
tour_logic.sv
tour_cmd.sv
knights_tour_top.sv
tb_knights_tour.sv

// ==== Bender.yml ====
package:
  name: knights_tour

sources:
  - include_dirs:
      - .
    files:
      - tour_pkg.sv
      - cmd_pkg.sv
      - tour_logic.sv
      - tour_cmd.sv
      - knights_tour_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_knights_tour.sv
